//--- project.f
rtl/cdd_link_pkg.sv
rtl/cdd_status_latch.sv
rtl/cdd_bit_shifter.sv
rtl/cdd_byte_sequencer.sv
rtl/cdd_command_frame.sv
rtl/cdd_link_top.sv
sim/cdd_link_tb.sv

//--- rtl/cdd_bit_shifter.sv
//////////////////////////////
// COMCLK edge detect, status bit shift out, host bit shift in
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdd_bit_shifter (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire cdd_link_pkg::cdd_link_in_t link_in,
	input  wire                          byte_load,
	input  wire cdd_link_pkg::cdd_byte_t load_byte,
	output logic                         byte_done,
	output cdd_link_pkg::cdd_byte_t      host_byte,
	output logic                         cdata,
	output logic                         comclk_rise
);

	import cdd_link_pkg::*;

	// previous comclk sample, idles high like the pin
	logic      comclk_q;
	logic      comclk_fall;
	// status bits still to go out
	cdd_byte_t out_shift;
	logic [2:0] bit_cnt;

	assign comclk_rise = link_in.comclk && !comclk_q;
	assign comclk_fall = !link_in.comclk && comclk_q;

	//////////////////////////////
	// edge detect and bit count
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			comclk_q  <= 1'b1;
			bit_cnt   <= '0;
			byte_done <= 1'b0;
			cdata     <= 1'b0;
		end else begin
			comclk_q  <= link_in.comclk;
			byte_done <= 1'b0;
			if (byte_load) begin
				bit_cnt <= '0;
			end else if (comclk_fall) begin
				// next status bit, lsb first
				cdata <= out_shift[0];
			end else if (comclk_rise) begin
				bit_cnt <= bit_cnt + 1'b1;
				// eighth bit closes the byte
				if (bit_cnt == 3'd7) begin
					byte_done <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// data shift registers
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (byte_load) begin
			out_shift <= load_byte;
		end else if (comclk_fall) begin
			out_shift <= {1'b0, out_shift[7:1]};
		end
	end

	// host bits arrive lsb first, so shift in from the top
	always_ff @(posedge clk_sys) begin
		if (!byte_load && comclk_rise) begin
			host_byte <= {link_in.hdata, host_byte[7:1]};
		end
	end

endmodule

`default_nettype wire

//--- rtl/cdd_byte_sequencer.sv
//////////////////////////////
// byte index, COMSYNC/COMREQ control and request delay
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdd_byte_sequencer (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          frame_start,
	input  wire cdd_link_pkg::cdd_frame_t status_bytes,
	input  wire                          byte_done,
	input  wire                          comclk_rise,
	output logic                         byte_load,
	output cdd_link_pkg::cdd_byte_t      load_byte,
	output logic                         frame_done,
	output logic                         comreq_n,
	output logic                         comsync_n
);

	import cdd_link_pkg::*;

	// byte now on the link, parked at IDLE_BYTE between frames
	cdd_byte_idx_t           byte_idx;
	logic                    byte_active;
	// counts down to the next comreq_n request
	logic [NEXT_DELAY_W-1:0] delay_cnt;
	logic                    more_bytes;

	assign byte_active = byte_idx <= LAST_BYTE;
	assign more_bytes  = byte_idx < LAST_BYTE;

	//////////////////////////////
	// next byte for the shifter
	//////////////////////////////

	always_comb begin
		byte_load = frame_start || (byte_done && byte_active);
		if (frame_start) begin
			load_byte = status_bytes[0];
		end else if (more_bytes) begin
			load_byte = status_bytes[byte_idx + 4'd1];
		end else begin
			// trailing byte after the last one is all zero
			load_byte = '0;
		end
	end

	//////////////////////////////
	// link control
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			byte_idx   <= IDLE_BYTE;
			delay_cnt  <= '0;
			frame_done <= 1'b0;
			comreq_n   <= 1'b1;
			comsync_n  <= 1'b1;
		end else begin
			frame_done <= 1'b0;

			if (delay_cnt != '0) begin
				delay_cnt <= delay_cnt - 1'b1;
			end

			// console has picked up the request
			if (comclk_rise) begin
				comreq_n <= 1'b1;
			end

			// request goes out as the delay expires
			if (delay_cnt == NEXT_DELAY_W'(1)) begin
				comreq_n <= 1'b0;
			end

			if (frame_start) begin
				// fresh frame, any transfer in flight is abandoned
				byte_idx  <= '0;
				comsync_n <= 1'b0;
				comreq_n  <= 1'b1;
				delay_cnt <= NEXT_DELAY_W'(1);
			end else if (byte_done && byte_active) begin
				comsync_n <= 1'b1;
				byte_idx  <= byte_idx + 4'd1;
				if (more_bytes) begin
					delay_cnt <= NEXT_DELAY_W'(NEXT_DELAY);
				end else begin
					// last byte in, no further request
					frame_done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/cdd_command_frame.sv
//////////////////////////////
// command byte collection and host frame publish
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdd_command_frame (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          frame_start,
	input  wire                          byte_done,
	input  wire cdd_link_pkg::cdd_byte_t host_byte,
	input  wire                          frame_done,
	output cdd_link_pkg::cdd_frame_t     command_frame,
	output logic                         command_toggle
);

	import cdd_link_pkg::*;

	// bytes of the transfer in progress
	cdd_frame_t collect_q;

	//////////////////////////////
	// byte collection
	//////////////////////////////

	// new bytes enter at the top and drift down, byte 0 ends lowest
	always_ff @(posedge clk_sys) begin
		if (frame_start) begin
			collect_q <= '0;
		end else if (byte_done) begin
			collect_q <= {host_byte, collect_q[FRAME_BYTES-1:1]};
		end
	end

	//////////////////////////////
	// publish to host
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			command_toggle <= 1'b0;
		end else if (frame_done) begin
			// flip marks a new frame for the host
			command_toggle <= ~command_toggle;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (frame_done) begin
			command_frame <= collect_q;
		end
	end

endmodule

`default_nettype wire

//--- rtl/cdd_link_pkg.sv
//////////////////////////////
// shared types and timing constants for the CD drive link bridge
//////////////////////////////
`default_nettype none

package cdd_link_pkg;

	//////////////////////////////
	// frame layout
	//////////////////////////////

	localparam int FRAME_BYTES = 12;

	// one byte on the serial link
	typedef logic [7:0] cdd_byte_t;

	// byte 0 sits lowest and goes out first
	typedef cdd_byte_t [FRAME_BYTES-1:0] cdd_frame_t;

	typedef logic [3:0] cdd_byte_idx_t;

	// index of the final byte, and the parked value between frames
	localparam cdd_byte_idx_t LAST_BYTE = cdd_byte_idx_t'(FRAME_BYTES - 1);
	localparam cdd_byte_idx_t IDLE_BYTE = cdd_byte_idx_t'(FRAME_BYTES);

	//////////////////////////////
	// console pins
	//////////////////////////////

	typedef struct packed {
		logic comclk;
		logic hdata;
	} cdd_link_in_t;

	typedef struct packed {
		logic cdata;
		logic comreq_n;
		logic comsync_n;
	} cdd_link_out_t;

	//////////////////////////////
	// timing
	//////////////////////////////

	// settle time after a new status frame
	localparam int START_WAIT   = 15;
	localparam int START_WAIT_W = 4;

	// gap between the end of a byte and the next request
	localparam int NEXT_DELAY   = 1023;
	localparam int NEXT_DELAY_W = 10;

endpackage

`default_nettype wire

//--- rtl/cdd_link_top.sv
//////////////////////////////
// CD drive link bridge top level
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdd_link_top (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire cdd_link_pkg::cdd_frame_t  status_frame,
	input  wire                           status_toggle,
	output cdd_link_pkg::cdd_frame_t      command_frame,
	output logic                          command_toggle,
	input  wire cdd_link_pkg::cdd_link_in_t link_in,
	output cdd_link_pkg::cdd_link_out_t   link_out
);

	import cdd_link_pkg::*;

	// latch to sequencer
	logic       frame_start;
	cdd_frame_t status_bytes;

	// sequencer and shifter strobes
	logic      byte_load;
	cdd_byte_t load_byte;
	logic      byte_done;
	cdd_byte_t host_byte;
	logic      comclk_rise;
	logic      frame_done;

	// console pins
	logic cdata;
	logic comreq_n;
	logic comsync_n;

	assign link_out = '{cdata: cdata, comreq_n: comreq_n, comsync_n: comsync_n};

	cdd_status_latch u_status_latch (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.status_frame  (status_frame),
		.status_toggle (status_toggle),
		.frame_start   (frame_start),
		.status_bytes  (status_bytes)
	);

	cdd_byte_sequencer u_byte_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.frame_start  (frame_start),
		.status_bytes (status_bytes),
		.byte_done    (byte_done),
		.comclk_rise  (comclk_rise),
		.byte_load    (byte_load),
		.load_byte    (load_byte),
		.frame_done   (frame_done),
		.comreq_n     (comreq_n),
		.comsync_n    (comsync_n)
	);

	cdd_bit_shifter u_bit_shifter (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.link_in     (link_in),
		.byte_load   (byte_load),
		.load_byte   (load_byte),
		.byte_done   (byte_done),
		.host_byte   (host_byte),
		.cdata       (cdata),
		.comclk_rise (comclk_rise)
	);

	cdd_command_frame u_command_frame (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.frame_start    (frame_start),
		.byte_done      (byte_done),
		.host_byte      (host_byte),
		.frame_done     (frame_done),
		.command_frame  (command_frame),
		.command_toggle (command_toggle)
	);

endmodule

`default_nettype wire

//--- rtl/cdd_status_latch.sv
//////////////////////////////
// host status frame capture and delayed transfer start
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdd_status_latch (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire cdd_link_pkg::cdd_frame_t status_frame,
	input  wire                        status_toggle,
	output logic                       frame_start,
	output cdd_link_pkg::cdd_frame_t   status_bytes
);

	import cdd_link_pkg::*;

	// last marker value seen from the host
	logic                    toggle_seen;
	// a start is waiting for the counter to run out
	logic                    start_pending;
	logic [START_WAIT_W-1:0] wait_cnt;
	logic                    toggle_change;

	assign toggle_change = status_toggle != toggle_seen;

	// strobe for one cycle once the wait has elapsed
	assign frame_start = start_pending && (wait_cnt == '0);

	//////////////////////////////
	// marker tracking and wait counter
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			toggle_seen   <= 1'b0;
			start_pending <= 1'b0;
			wait_cnt      <= '0;
		end else begin
			if (toggle_change) begin
				// any new frame restarts the wait, even mid transfer
				toggle_seen   <= status_toggle;
				start_pending <= 1'b1;
				wait_cnt      <= START_WAIT_W'(START_WAIT);
			end else if (start_pending) begin
				if (wait_cnt != '0) begin
					wait_cnt <= wait_cnt - 1'b1;
				end else begin
					start_pending <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////
	// frame storage
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (toggle_change) begin
			status_bytes <= status_frame;
		end
	end

endmodule

`default_nettype wire

//--- sim/cdd_link_tb.sv
//////////////////////////////
// directed testbench for the CD drive link bridge
// console emulation, compare tasks and watchdog
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdd_link_tb;

	import cdd_link_pkg::*;

	localparam int DRIVE_DELAY = 10;
	localparam int REQ_WAIT    = NEXT_DELAY + START_WAIT + 100;
	localparam int TEST_FRAMES = 5;
	localparam int WATCHDOG_CYCLES = TEST_FRAMES * FRAME_BYTES * (NEXT_DELAY + 80) + 10000;

	logic          clk_sys;
	logic          reset;
	cdd_frame_t    status_frame;
	logic          status_toggle;
	cdd_frame_t    command_frame;
	logic          command_toggle;
	cdd_link_in_t  link_in;
	cdd_link_out_t link_out;

	integer seed;
	int     check_count;
	int     error_count;
	// command_toggle level the host should see now
	logic   toggle_model;

	cdd_link_top u_dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.status_frame   (status_frame),
		.status_toggle  (status_toggle),
		.command_frame  (command_frame),
		.command_toggle (command_toggle),
		.link_in        (link_in),
		.link_out       (link_out)
	);

	always #50 clk_sys = ~clk_sys;

	//////////////////////////////
	// helpers and compare tasks
	//////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic report_problem(input string msg);
		error_count++;
		$display("%s", msg);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("error %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input cdd_byte_t exp, input cdd_byte_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("error %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_frame(input string name, input cdd_frame_t exp, input cdd_frame_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("error %s expected %h actual %h", name, exp, act);
		end
	endtask

	function automatic cdd_frame_t random_frame();
		cdd_frame_t f;
		for (int i = 0; i < FRAME_BYTES; i++) begin
			f[i] = cdd_byte_t'($random(seed));
		end
		return f;
	endfunction

	// new host frame is marked by flipping the toggle
	task automatic send_status(input cdd_frame_t f);
		status_frame  = f;
		status_toggle = ~status_toggle;
		next_cycle();
	endtask

	//////////////////////////////
	// console side emulation
	//////////////////////////////

	// one byte exchange with 4 cycles low and 4 high per bit
	task automatic exchange_byte(input string name, input int idx, input cdd_byte_t host_val,
			output cdd_byte_t status_val, output bit ok);
		int wait_cnt;
		wait_cnt   = 0;
		status_val = '0;
		ok         = 1'b0;
		while (link_out.comreq_n !== 1'b0 && wait_cnt < REQ_WAIT) begin
			next_cycle();
			wait_cnt++;
		end
		if (link_out.comreq_n !== 1'b0) begin
			report_problem($sformatf("%s: comreq_n never went low for byte %0d", name, idx));
			return;
		end
		// sync marks byte 0 only
		check_bit($sformatf("%s comsync_n byte %0d", name, idx), idx != 0, link_out.comsync_n);
		for (int b = 0; b < 8; b++) begin
			link_in.comclk = 1'b0;
			repeat (4) next_cycle();
			if (b == 0) begin
				// request holds until the first rising edge
				check_bit($sformatf("%s comreq_n hold byte %0d", name, idx), 1'b0,
					link_out.comreq_n);
			end
			link_in.comclk = 1'b1;
			link_in.hdata  = host_val[b];
			repeat (4) next_cycle();
			status_val[b] = link_out.cdata;
			if (b == 0) begin
				check_bit($sformatf("%s comreq_n release byte %0d", name, idx), 1'b1,
					link_out.comreq_n);
				check_bit($sformatf("%s comsync_n in byte %0d", name, idx), idx != 0,
					link_out.comsync_n);
			end
		end
		ok = 1'b1;
	endtask

	// full frame followed by the command frame and a quiet link
	task automatic run_frame(input string name, input cdd_frame_t status, input cdd_frame_t cmd);
		cdd_byte_t got;
		bit        ok;
		logic      toggle_exp;
		int        wait_cnt;
		bit        extra_req;
		bit        flipped_again;
		toggle_exp    = ~toggle_model;
		extra_req     = 1'b0;
		flipped_again = 1'b0;
		for (int i = 0; i < FRAME_BYTES; i++) begin
			exchange_byte(name, i, cmd[i], got, ok);
			if (!ok) begin
				return;
			end
			check_byte($sformatf("%s cdata byte %0d", name, i), status[i], got);
		end
		wait_cnt = 0;
		while (command_toggle !== toggle_exp && wait_cnt < 20) begin
			next_cycle();
			wait_cnt++;
		end
		check_bit($sformatf("%s command_toggle", name), toggle_exp, command_toggle);
		check_frame($sformatf("%s command_frame", name), cmd, command_frame);
		toggle_model = toggle_exp;
		repeat (NEXT_DELAY + 50) begin
			next_cycle();
			if (link_out.comreq_n === 1'b0) begin
				extra_req = 1'b1;
			end
			if (command_toggle !== toggle_exp) begin
				flipped_again = 1'b1;
			end
		end
		if (extra_req) begin
			report_problem($sformatf("%s: comreq_n requested a byte after the last one", name));
		end
		if (flipped_again) begin
			report_problem($sformatf("%s: command_toggle flipped more than once", name));
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic test_reset_state();
		check_bit("reset comreq_n", 1'b1, link_out.comreq_n);
		check_bit("reset comsync_n", 1'b1, link_out.comsync_n);
		check_bit("reset cdata", 1'b0, link_out.cdata);
		check_bit("reset command_toggle", 1'b0, command_toggle);
	endtask

	task automatic test_single_frame();
		cdd_frame_t status;
		cdd_frame_t cmd;
		status = 96'hc3_5a_a5_3c_96_69_f0_0f_81_18_e7_7e;
		cmd    = 96'h01_23_45_67_89_ab_cd_ef_fe_dc_ba_98;
		send_status(status);
		run_frame("single_frame", status, cmd);
	endtask

	task automatic test_two_frames();
		cdd_frame_t status;
		cdd_frame_t cmd;
		for (int n = 0; n < 2; n++) begin
			status = random_frame();
			cmd    = random_frame();
			send_status(status);
			run_frame($sformatf("random_frame_%0d", n), status, cmd);
		end
	endtask

	// new toggle after byte 3 drops the partial transfer
	task automatic test_restart();
		cdd_frame_t first_status;
		cdd_frame_t first_cmd;
		cdd_frame_t status;
		cdd_frame_t cmd;
		cdd_byte_t  got;
		bit         ok;
		first_status = random_frame();
		first_cmd    = random_frame();
		status       = random_frame();
		cmd          = random_frame();
		send_status(first_status);
		for (int i = 0; i < 4; i++) begin
			exchange_byte("restart_partial", i, first_cmd[i], got, ok);
			if (!ok) begin
				return;
			end
			check_byte($sformatf("restart_partial cdata byte %0d", i), first_status[i], got);
		end
		send_status(status);
		run_frame("restart", status, cmd);
	endtask

	//////////////////////////////
	// run control
	//////////////////////////////

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("run timed out waiting for the link");
		$display("checks %0d errors %0d", check_count, error_count + 1);
		$display("Checks failed");
		$finish;
	end

	initial begin
		clk_sys        = 1'b0;
		reset          = 1'b1;
		status_frame   = '0;
		status_toggle  = 1'b0;
		link_in.comclk = 1'b1;
		link_in.hdata  = 1'b0;
		seed           = 32'h38f4;
		check_count    = 0;
		error_count    = 0;
		toggle_model   = 1'b0;
		repeat (10) next_cycle();
		reset = 1'b0;
		next_cycle();
		test_reset_state();
		test_single_frame();
		test_two_frames();
		test_restart();
		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
